// ==== include/vec_defines.svh ====
// Size and encoding macros of the vector unit, included by the type and control packages

`ifndef VEC_DEFINES_SVH
`define VEC_DEFINES_SVH

////////////////////////////////////////////////////////////
// Data path sizes
////////////////////////////////////////////////////////////

// Parallel lanes, one element of every register per lane
`define VEC_NR_LANES 4

// Bits per element and per scalar operand
`define VEC_ELEM_W 32

// Architectural vector registers
`define VEC_NR_VREGS 8

////////////////////////////////////////////////////////////
// Control encodings
////////////////////////////////////////////////////////////

// Eight operations fit in three bits
`define VEC_OP_W 3

`endif

// ==== logic/vec_ctrl_pkg.sv ====
// Control encodings of the vector unit: opcodes and dispatcher states

`include "vec_defines.svh"

package vec_ctrl_pkg;

  // Operations accepted on the request port
  typedef enum logic [`VEC_OP_W-1:0] {
    VADD    = 3'd0,
    VSUB    = 3'd1,
    VAND    = 3'd2,
    VOR     = 3'd3,
    VXOR    = 3'd4,
    // Scalar broadcast into vd
    VMV_VX  = 3'd5,
    // Sum of all elements of vs2
    VREDSUM = 3'd6,
    // Element of vs2 picked by the scalar's low bits
    VEXT    = 3'd7
  } vec_op_e;

  // Dispatcher FSM, one instruction in flight
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    ISSUE     = 2'd1,
    WAIT_RESP = 2'd2
  } disp_state_e;

endpackage

// ==== logic/vec_dispatcher.sv ====
// Decode stage of the vector unit: takes core requests and issues them one at a time

`timescale 1ns/1ps

module vec_dispatcher (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // Request port of the core
  input  logic                     acc_req_valid_i,
  output logic                     acc_req_ready_o,
  input  vec_ctrl_pkg::vec_op_e    acc_req_op_i,
  input  vec_types_pkg::vreg_idx_t acc_req_vd_i,
  input  vec_types_pkg::vreg_idx_t acc_req_vs1_i,
  input  vec_types_pkg::vreg_idx_t acc_req_vs2_i,
  input  vec_types_pkg::elem_t     acc_req_scalar_i,
  // Response handshake done in the result stage
  input  logic                     resp_done_i,
  // Towards lanes and result stage
  vec_issue_if.disp                issue
);

  vec_ctrl_pkg::disp_state_e state_q, state_d;
  logic                      req_fire;
  logic                      issue_valid_q;

  // Held request
  vec_ctrl_pkg::vec_op_e     op_q;
  vec_types_pkg::vreg_idx_t  vd_q;
  vec_types_pkg::vreg_idx_t  vs1_q;
  vec_types_pkg::vreg_idx_t  vs2_q;
  vec_types_pkg::elem_t      scalar_q;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  // Only an empty unit takes a new request
  assign acc_req_ready_o = (state_q == vec_ctrl_pkg::IDLE);
  assign req_fire        = acc_req_valid_i & acc_req_ready_o;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      vec_ctrl_pkg::IDLE: begin
        if (req_fire) state_d = vec_ctrl_pkg::ISSUE;
      end
      vec_ctrl_pkg::ISSUE: state_d = vec_ctrl_pkg::WAIT_RESP;
      vec_ctrl_pkg::WAIT_RESP: begin
        if (resp_done_i) state_d = vec_ctrl_pkg::IDLE;
      end
      default: state_d = vec_ctrl_pkg::IDLE;
    endcase
  end

  // Issue pulse leaves the ISSUE state registered, so lanes see a clean strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= vec_ctrl_pkg::IDLE;
      issue_valid_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      issue_valid_q <= (state_q == vec_ctrl_pkg::ISSUE);
    end
  end

  ////////////////////////////////////////////////////////////
  // Request capture
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      op_q     <= acc_req_op_i;
      vd_q     <= acc_req_vd_i;
      vs1_q    <= acc_req_vs1_i;
      vs2_q    <= acc_req_vs2_i;
      scalar_q <= acc_req_scalar_i;
    end
  end

  assign issue.issue_valid = issue_valid_q;
  assign issue.op          = op_q;
  assign issue.vd          = vd_q;
  assign issue.vs1         = vs1_q;
  assign issue.vs2         = vs2_q;
  assign issue.scalar      = scalar_q;

endmodule

// ==== logic/vec_issue_if.sv ====
// Issue bus carrying one decoded instruction from the dispatcher to the lanes and result stage

`timescale 1ns/1ps

interface vec_issue_if;

  // One-cycle pulse per instruction, no back-pressure
  logic                      issue_valid;
  vec_ctrl_pkg::vec_op_e     op;
  vec_types_pkg::vreg_idx_t  vd;
  vec_types_pkg::vreg_idx_t  vs1;
  vec_types_pkg::vreg_idx_t  vs2;
  vec_types_pkg::elem_t      scalar;

  // Driving side
  modport disp (output issue_valid, output op, output vd, output vs1, output vs2,
                output scalar);

  // Every lane sees the whole instruction
  modport lane (input issue_valid, input op, input vd, input vs1, input vs2, input scalar);

  // Result stage only needs what shapes the response
  modport res (input issue_valid, input op, input scalar);

endinterface

// ==== logic/vec_lane.sv ====
// Execute stage of one lane: register file slice, element ALU and element read-out

`timescale 1ns/1ps

`include "vec_defines.svh"

module vec_lane #(
  parameter int unsigned lane_id = 0
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  vec_issue_if.lane            issue,
  output vec_types_pkg::elem_t elem_o,
  output logic                 elem_valid_o
);

  // This lane's element of every vector register
  vec_types_pkg::elem_t rf_q [`VEC_NR_VREGS];

  vec_types_pkg::elem_t src1;
  vec_types_pkg::elem_t src2;
  vec_types_pkg::elem_t alu_res;
  logic                 wr_en;

  assign src1 = rf_q[issue.vs1];
  assign src2 = rf_q[issue.vs2];

  ////////////////////////////////////////////////////////////
  // Element ALU
  ////////////////////////////////////////////////////////////

  // Subtraction is vs2 - vs1, all arithmetic wraps modulo 2^32
  always_comb begin
    alu_res = '0;
    wr_en   = issue.issue_valid;
    unique case (issue.op)
      vec_ctrl_pkg::VADD:   alu_res = src2 + src1;
      vec_ctrl_pkg::VSUB:   alu_res = src2 - src1;
      vec_ctrl_pkg::VAND:   alu_res = src2 & src1;
      vec_ctrl_pkg::VOR:    alu_res = src2 | src1;
      vec_ctrl_pkg::VXOR:   alu_res = src2 ^ src1;
      vec_ctrl_pkg::VMV_VX: alu_res = issue.scalar;
      // Reduction and extraction leave the register file alone
      default:              wr_en   = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `VEC_NR_VREGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (wr_en) begin
      rf_q[issue.vd] <= alu_res;
    end
  end

  ////////////////////////////////////////////////////////////
  // Element read-out
  ////////////////////////////////////////////////////////////

  // Every issue loads this lane's vs2 element for the result stage
  always_ff @(posedge clk_i) begin
    if (issue.issue_valid) elem_o <= src2;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) elem_valid_o <= 1'b0;
    else           elem_valid_o <= issue.issue_valid;
  end

endmodule

// ==== logic/vec_result.sv ====
// Result stage: merges lane elements into one scalar response and holds it until taken

`timescale 1ns/1ps

`include "vec_defines.svh"

module vec_result (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  vec_issue_if.res                    issue,
  // Lane elements, valid together
  input  vec_types_pkg::lane_elems_t  elems_i,
  input  logic                        elems_valid_i,
  // Response port of the core
  output logic                        acc_resp_valid_o,
  input  logic                        acc_resp_ready_i,
  output vec_types_pkg::elem_t        acc_resp_result_o,
  // Back to the dispatcher
  output logic                        resp_done_o
);

  vec_ctrl_pkg::vec_op_e    op_q;
  vec_types_pkg::elem_t     scalar_q;
  vec_types_pkg::lane_idx_t ext_idx;
  vec_types_pkg::elem_t     red_sum;
  vec_types_pkg::elem_t     ext_elem;
  vec_types_pkg::elem_t     resp_d;

  // Op and scalar are gone from the bus by the time lanes answer
  always_ff @(posedge clk_i) begin
    if (issue.issue_valid) begin
      op_q     <= issue.op;
      scalar_q <= issue.scalar;
    end
  end

  ////////////////////////////////////////////////////////////
  // Merge
  ////////////////////////////////////////////////////////////

  assign ext_idx  = scalar_q[$bits(vec_types_pkg::lane_idx_t)-1:0];
  assign ext_elem = elems_i[ext_idx*`VEC_ELEM_W +: `VEC_ELEM_W];

  always_comb begin
    red_sum = '0;
    for (int i = 0; i < `VEC_NR_LANES; i++) begin
      red_sum = red_sum + elems_i[i*`VEC_ELEM_W +: `VEC_ELEM_W];
    end
  end

  // Element-wise ops answer with zero
  always_comb begin
    unique case (op_q)
      vec_ctrl_pkg::VREDSUM: resp_d = red_sum;
      vec_ctrl_pkg::VEXT:    resp_d = ext_elem;
      default:               resp_d = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Response hold
  ////////////////////////////////////////////////////////////

  assign resp_done_o = acc_resp_valid_o & acc_resp_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i)          acc_resp_valid_o <= 1'b0;
    else if (elems_valid_i) acc_resp_valid_o <= 1'b1;
    else if (resp_done_o)   acc_resp_valid_o <= 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (elems_valid_i) acc_resp_result_o <= resp_d;
  end

endmodule

// ==== logic/vec_types_pkg.sv ====
// Data-path types of the vector unit, referenced by scoped name from the RTL and testbench

`include "vec_defines.svh"

package vec_types_pkg;

  // One element, or the scalar operand of the core
  typedef logic [`VEC_ELEM_W-1:0] elem_t;

  // Vector register number
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0] vreg_idx_t;

  // Lane number, equal to the element index inside a register
  typedef logic [$clog2(`VEC_NR_LANES)-1:0] lane_idx_t;

  // One element per lane, lane 0 in the low bits
  typedef logic [`VEC_NR_LANES*`VEC_ELEM_W-1:0] lane_elems_t;

endpackage

// ==== logic/vec_unit.sv ====
// Top level of the vector unit: dispatcher, lanes and result stage behind the core's port

`timescale 1ns/1ps

`include "vec_defines.svh"

module vec_unit (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // Request
  input  logic                     acc_req_valid_i,
  output logic                     acc_req_ready_o,
  input  vec_ctrl_pkg::vec_op_e    acc_req_op_i,
  input  vec_types_pkg::vreg_idx_t acc_req_vd_i,
  input  vec_types_pkg::vreg_idx_t acc_req_vs1_i,
  input  vec_types_pkg::vreg_idx_t acc_req_vs2_i,
  input  vec_types_pkg::elem_t     acc_req_scalar_i,
  // Response
  output logic                     acc_resp_valid_o,
  input  logic                     acc_resp_ready_i,
  output vec_types_pkg::elem_t     acc_resp_result_o
);

  vec_issue_if issue_if ();

  vec_types_pkg::lane_elems_t lane_elems;
  logic [`VEC_NR_LANES-1:0]   lane_valid;
  logic                       resp_done;

  ////////////////////////////////////////////////////////////
  // Dispatcher
  ////////////////////////////////////////////////////////////

  vec_dispatcher i_dispatcher (
    .clk_i            (clk_i           ),
    .arst_n_i         (arst_n_i        ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_req_op_i     (acc_req_op_i    ),
    .acc_req_vd_i     (acc_req_vd_i    ),
    .acc_req_vs1_i    (acc_req_vs1_i   ),
    .acc_req_vs2_i    (acc_req_vs2_i   ),
    .acc_req_scalar_i (acc_req_scalar_i),
    .resp_done_i      (resp_done       ),
    .issue            (issue_if.disp   )
  );

  ////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////

  for (genvar l = 0; l < `VEC_NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .lane_id (l)
    ) i_lane (
      .clk_i        (clk_i                                      ),
      .arst_n_i     (arst_n_i                                   ),
      .issue        (issue_if.lane                              ),
      .elem_o       (lane_elems[l*`VEC_ELEM_W +: `VEC_ELEM_W]),
      .elem_valid_o (lane_valid[l]                              )
    );
  end : gen_lanes

  ////////////////////////////////////////////////////////////
  // Result stage
  ////////////////////////////////////////////////////////////

  // Lanes run in lockstep, lane 0 speaks for all
  vec_result i_result (
    .clk_i             (clk_i            ),
    .arst_n_i          (arst_n_i         ),
    .issue             (issue_if.res     ),
    .elems_i           (lane_elems       ),
    .elems_valid_i     (lane_valid[0]    ),
    .acc_resp_valid_o  (acc_resp_valid_o ),
    .acc_resp_ready_i  (acc_resp_ready_i ),
    .acc_resp_result_o (acc_resp_result_o),
    .resp_done_o       (resp_done        )
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the vector unit testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=vec_tb_sim
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module vec_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status, see $LOG"
  exit 1
fi

echo "Simulation finished without reported failure"
exit 0

// ==== src.f ====
+incdir+include
logic/vec_types_pkg.sv
logic/vec_ctrl_pkg.sv
logic/vec_issue_if.sv
logic/vec_dispatcher.sv
logic/vec_lane.sv
logic/vec_result.sv
logic/vec_unit.sv
verif/vec_properties.sv
verif/vec_tb_clkgen.sv
verif/vec_tb.sv

// ==== verif/vec_cases.txt ====
// First word: case count. Then per line: op vd vs1 vs2 scalar expected_result stall_cycles
// op: 0 vadd, 1 vsub, 2 vand, 3 vor, 4 vxor, 5 vmv_vx, 6 vredsum, 7 vext; all fields in hex
16
6 0 0 3 00000000 00000000 0
7 0 0 5 00000002 00000000 1
5 1 0 0 12345678 00000000 0
7 0 0 1 00000000 12345678 0
7 0 0 1 00000001 12345678 2
7 0 0 1 00000002 12345678 0
7 0 0 1 00000007 12345678 0
6 0 0 1 00000000 48d159e0 3
5 2 0 0 f0f0f0f0 00000000 0
6 0 0 2 00000000 c3c3c3c0 0
0 3 1 2 00000000 00000000 4
7 0 0 3 00000002 03254768 0
1 4 2 1 00000000 00000000 0
7 0 0 4 00000003 21436588 0
6 0 0 4 00000000 850d9620 0
2 5 1 2 00000000 00000000 0
7 0 0 5 00000001 10305070 0
3 6 1 2 00000000 00000000 1
7 0 0 6 00000000 f2f4f6f8 0
4 7 1 2 00000000 00000000 0
7 0 0 7 00000002 e2c4a688 0
6 0 0 7 00000000 8b129a20 5

// ==== verif/vec_properties.sv ====
// Concurrent checks on the request and response handshake of the vector unit, bound to its top

`timescale 1ns/1ps

module vec_properties (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input logic                 req_valid_i,
  input logic                 req_ready_i,
  input logic                 resp_valid_i,
  input logic                 resp_ready_i,
  input vec_types_pkg::elem_t resp_result_i
);

  logic req_fire;

  assign req_fire = req_valid_i & req_ready_i;

  ////////////////////////////////////////////////////////////
  // Handshake rules
  ////////////////////////////////////////////////////////////

  // Held response keeps valid and data until taken
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_result_i))
    else $error("response changed while waiting for ready");

  // One instruction in flight
  assert property (@(posedge clk_i) disable iff (!arst_n_i) req_fire |=> !req_ready_i)
    else $error("request port still ready after acceptance");

  assert property (@(posedge clk_i) disable iff (!arst_n_i) resp_valid_i |-> !req_ready_i)
    else $error("request port ready while a response is pending");

  // Reset values of the port
  assert property (@(posedge clk_i) !arst_n_i |-> !resp_valid_i && req_ready_i)
    else $error("handshake signals wrong during reset");

  // Accepted on edge E, valid driven on E+3 and first sampled on E+4
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(resp_valid_i) == $past(req_fire, 4))
    else $error("response latency differs from three cycles");

endmodule

bind vec_unit vec_properties i_properties (
  .clk_i         (clk_i            ),
  .arst_n_i      (arst_n_i         ),
  .req_valid_i   (acc_req_valid_i  ),
  .req_ready_i   (acc_req_ready_o  ),
  .resp_valid_i  (acc_resp_valid_o ),
  .resp_ready_i  (acc_resp_ready_i ),
  .resp_result_i (acc_resp_result_o)
);

// ==== verif/vec_tb.sv ====
// Testbench top of the vector unit: replays the case file through the core port and checks results

`timescale 1ns/1ps

module vec_tb;

  localparam string       CASE_FILE     = "verif/vec_cases.txt";
  localparam int          CASE_WORDS    = 7;
  localparam int          MAX_CASES     = 64;
  localparam int          CLK_PERIOD_NS = 4;
  localparam int          DRIVE_DLY_NS  = 1;
  localparam int unsigned RESP_LATENCY  = 3;

  logic clk;
  logic arst_n;

  logic                     req_valid;
  logic                     req_ready;
  vec_ctrl_pkg::vec_op_e    req_op;
  vec_types_pkg::vreg_idx_t req_vd;
  vec_types_pkg::vreg_idx_t req_vs1;
  vec_types_pkg::vreg_idx_t req_vs2;
  vec_types_pkg::elem_t     req_scalar;
  logic                     resp_valid;
  logic                     resp_ready;
  vec_types_pkg::elem_t     resp_result;

  // Word 0 is the case count, then CASE_WORDS words per case
  logic [31:0] case_mem [1 + MAX_CASES * CASE_WORDS];
  int          n_cases;
  logic        cases_ready;

  vec_tb_clkgen i_clkgen (
    .clk_o    (clk   ),
    .arst_n_o (arst_n)
  );

  vec_unit i_dut (
    .clk_i             (clk        ),
    .arst_n_i          (arst_n     ),
    .acc_req_valid_i   (req_valid  ),
    .acc_req_ready_o   (req_ready  ),
    .acc_req_op_i      (req_op     ),
    .acc_req_vd_i      (req_vd     ),
    .acc_req_vs1_i     (req_vs1    ),
    .acc_req_vs2_i     (req_vs2    ),
    .acc_req_scalar_i  (req_scalar ),
    .acc_resp_valid_o  (resp_valid ),
    .acc_resp_ready_i  (resp_ready ),
    .acc_resp_result_o (resp_result)
  );

  ////////////////////////////////////////////////////////////
  // Helpers and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  // Outputs are settled here, and new inputs go out
  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DLY_NS);
  endtask

  task automatic check_result(input vec_types_pkg::elem_t exp, input vec_types_pkg::elem_t act,
                              input string sig);
    if (act !== exp) begin
      $display("ERR time=%0t %s expected=%h actual=%h", $time, sig, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_latency(input int unsigned exp, input int unsigned act);
    if (act != exp) begin
      $display("ERR time=%0t response latency expected=%0d actual=%0d", $time, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_ready(input logic exp, input logic act, input string sig);
    if (act !== exp) begin
      $display("ERR time=%0t %s expected=%b actual=%b", $time, sig, exp, act);
      stop_with_failure();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One instruction from request to response handshake
  ////////////////////////////////////////////////////////////

  task automatic run_case(input int idx);
    int                   base;
    int unsigned          stall;
    int unsigned          lat;
    vec_types_pkg::elem_t expected;
    base       = 1 + idx * CASE_WORDS;
    req_op     = vec_ctrl_pkg::vec_op_e'(case_mem[base][$bits(vec_ctrl_pkg::vec_op_e)-1:0]);
    req_vd     = vec_types_pkg::vreg_idx_t'(case_mem[base + 1]);
    req_vs1    = vec_types_pkg::vreg_idx_t'(case_mem[base + 2]);
    req_vs2    = vec_types_pkg::vreg_idx_t'(case_mem[base + 3]);
    req_scalar = case_mem[base + 4];
    expected   = case_mem[base + 5];
    stall      = case_mem[base + 6];
    req_valid  = 1'b1;
    resp_ready = 1'b0;
    while (!req_ready) next_cycle();
    // Acceptance edge
    next_cycle();
    req_valid = 1'b0;
    lat       = 0;
    while (!resp_valid) begin
      check_ready(1'b0, req_ready, "acc_req_ready_o");
      next_cycle();
      lat++;
    end
    check_latency(RESP_LATENCY, lat);
    check_result(expected, resp_result, "acc_resp_result_o");
    repeat (stall) begin
      next_cycle();
      check_ready(1'b1, resp_valid, "acc_resp_valid_o");
      check_result(expected, resp_result, "acc_resp_result_o");
      check_ready(1'b0, req_ready, "acc_req_ready_o");
    end
    resp_ready = 1'b1;
    // Response handshake edge
    next_cycle();
    resp_ready = 1'b0;
    check_ready(1'b0, resp_valid, "acc_resp_valid_o");
    check_ready(1'b1, req_ready, "acc_req_ready_o");
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin : main
    req_valid   = 1'b0;
    req_op      = vec_ctrl_pkg::VADD;
    req_vd      = '0;
    req_vs1     = '0;
    req_vs2     = '0;
    req_scalar  = '0;
    resp_ready  = 1'b0;
    cases_ready = 1'b0;
    $readmemh(CASE_FILE, case_mem);
    n_cases = int'(case_mem[0]);
    if (n_cases <= 0 || n_cases > MAX_CASES) begin
      $display("Case file holds no usable case count: %0d", n_cases);
      stop_with_failure();
    end
    cases_ready = 1'b1;
    @(negedge arst_n);
    @(posedge arst_n);
    next_cycle();
    check_ready(1'b1, req_ready, "acc_req_ready_o");
    check_ready(1'b0, resp_valid, "acc_resp_valid_o");
    for (int i = 0; i < n_cases; i++) begin
      run_case(i);
    end
    $display("Test passed");
    $finish;
  end

  // Thirty cycles per case is far above the worst stall in the file
  initial begin : watchdog
    wait (cases_ready);
    #((n_cases * 30 + 40) * CLK_PERIOD_NS);
    $display("Timeout: run did not finish within %0d cycles", n_cases * 30 + 40);
    stop_with_failure();
  end

endmodule

// ==== verif/vec_tb_clkgen.sv ====
// Testbench clock and reset source: 4 ns clock, active-low reset held for 16 cycles

`timescale 1ns/1ps

module vec_tb_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HALF_PERIOD_NS = 2;
  localparam int RESET_CYCLES   = 16;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Short high phase at time zero gives the async reset a real falling edge
  initial begin
    arst_n_o = 1'b1;
    #1;
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    arst_n_o = 1'b1;
  end

endmodule
